// ==== logic/dmr_cfg_pkg.sv ====
// pair count must be a power of two; register count is fixed at two to the address width
package dmr_cfg_pkg;

  // lockstep core pairs checked by this subsystem
  localparam int unsigned NumGroups = 4;

  // bits needed to index one pair
  localparam int unsigned GroupIdxWidth = $clog2(NumGroups);

  // register file geometry of one core
  localparam int unsigned RfAddrWidth = 5;
  localparam int unsigned RfDataWidth = 32;

  // every address is populated, replay covers all of them
  localparam int unsigned NumRegs = 1 << RfAddrWidth;

endpackage : dmr_cfg_pkg

// ==== logic/recovery_pkg.sv ====
// types only; widths follow dmr_cfg_pkg, which must be compiled first
package recovery_pkg;

  // register address as seen by cores and replay bus
  typedef logic [dmr_cfg_pkg::RfAddrWidth-1:0] rf_addr_t;

  // one architectural register word
  typedef logic [dmr_cfg_pkg::RfDataWidth-1:0] rf_data_t;

  // index of a core pair
  typedef logic [dmr_cfg_pkg::GroupIdxWidth-1:0] group_idx_t;

  // recovery routine steps
  // no pc or csr restore in this version
  typedef enum logic [2:0] {
    IDLE,
    RESET,
    HALT_REQ,
    HALT_WAIT,
    RESTORE_RF,
    RESUME
  } recovery_state_e;

endpackage : recovery_pkg

// ==== logic/dmr_error_arbiter.sv ====
// takes one error at a time; later errors are lost until clear_i, highest pair wins ties
`timescale 1ns/1ps

module dmr_error_arbiter (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic       [dmr_cfg_pkg::NumGroups-1:0] rf_err_a_i,
  input  logic       [dmr_cfg_pkg::NumGroups-1:0] rf_err_b_i,
  input  logic       [dmr_cfg_pkg::NumGroups-1:0] core_err_main_i,
  input  logic       [dmr_cfg_pkg::NumGroups-1:0] core_err_data_i,
  input  logic                                 clear_i,
  output logic                                 start_o,
  output recovery_pkg::group_idx_t             group_o,
  output logic       [dmr_cfg_pkg::NumGroups-1:0] error_o
);

  import dmr_cfg_pkg::*;
  import recovery_pkg::*;

  logic [NumGroups-1:0] err_any;
  group_idx_t           err_idx;
  logic                 pending_q;
  logic                 start_q;
  group_idx_t           group_q;

  // one flag per pair from all four checkers
  assign err_any = rf_err_a_i | rf_err_b_i | core_err_main_i | core_err_data_i;
  assign error_o = err_any;

  // ascending scan, last hit is the highest pair
  always_comb begin
    err_idx = '0;
    for (int g = 0; g < NumGroups; g++) begin
      if (err_any[g]) begin
        err_idx = group_idx_t'(g);
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      start_q   <= 1'b0;
      group_q   <= '0;
    end else begin
      // single cycle pulse
      start_q <= 1'b0;
      if (clear_i) begin
        // routine done, arm for next error
        pending_q <= 1'b0;
      end else if (!pending_q && |err_any) begin
        pending_q <= 1'b1;
        start_q   <= 1'b1;
        group_q   <= err_idx;
      end
    end
  end

  assign start_o = start_q;
  // held stable for the whole routine
  assign group_o = group_q;

endmodule : dmr_error_arbiter

// ==== logic/rf_addr_gen.sv ====
// address sits at zero while disabled and holds at the last one if enable stays high
`timescale 1ns/1ps

module rf_addr_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   enable_i,
  output recovery_pkg::rf_addr_t addr_o,
  output logic                   done_o
);

  import dmr_cfg_pkg::*;
  import recovery_pkg::*;

  localparam rf_addr_t LastAddr = rf_addr_t'(NumRegs - 1);

  rf_addr_t addr_q;
  rf_addr_t addr_d;

  always_comb begin
    addr_d = addr_q;
    if (!enable_i) begin
      // ready at zero for the next sweep
      addr_d = '0;
    end else if (addr_q != LastAddr) begin
      addr_d = addr_q + rf_addr_t'(1);
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else begin
      addr_q <= addr_d;
    end
  end

  assign addr_o = addr_q;
  // last address while sweeping
  assign done_o = enable_i && (addr_q == LastAddr);

endmodule : rf_addr_gen

// ==== logic/recovery_regfile.sv ====
// trusted copy only; writes in error or recover cycles of a pair are dropped, read is comb
`timescale 1ns/1ps

module recovery_regfile (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic [dmr_cfg_pkg::NumGroups-1:0]           error_i,
  input  logic [dmr_cfg_pkg::NumGroups-1:0]           recover_i,
  input  logic [dmr_cfg_pkg::NumGroups-1:0]           wr_en_i,
  input  recovery_pkg::rf_addr_t [dmr_cfg_pkg::NumGroups-1:0] wr_addr_i,
  input  recovery_pkg::rf_data_t [dmr_cfg_pkg::NumGroups-1:0] wr_data_i,
  input  recovery_pkg::group_idx_t                    rd_group_i,
  input  recovery_pkg::rf_addr_t                      rd_addr_i,
  output recovery_pkg::rf_data_t                      rd_data_o
);

  import dmr_cfg_pkg::*;
  import recovery_pkg::*;

  // one bank per pair
  rf_data_t             mem_q [NumGroups][NumRegs];
  logic [NumGroups-1:0] wr_ok;

  // a pair flagged this cycle may be writing corrupted data
  // a pair in replay gets its registers from here, not the reverse
  assign wr_ok = wr_en_i & ~error_i & ~recover_i;

  // cleared at reset so replay of unwritten registers gives zero
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int g = 0; g < NumGroups; g++) begin
        for (int r = 0; r < NumRegs; r++) begin
          mem_q[g][r] <= '0;
        end
      end
    end else begin
      // pairs write independently, same cycle allowed
      for (int g = 0; g < NumGroups; g++) begin
        if (wr_ok[g]) begin
          mem_q[g][wr_addr_i[g]] <= wr_data_i[g];
        end
      end
    end
  end

  // replay port
  // data appears in the cycle the address is given
  assign rd_data_o = mem_q[rd_group_i][rd_addr_i];

endmodule : recovery_regfile

// ==== logic/dmr_recovery_ctrl.sv ====
// one pair at a time; group_i must hold until clear_o, halt wait has no timeout
`timescale 1ns/1ps

module dmr_recovery_ctrl (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 start_i,
  input  recovery_pkg::group_idx_t             group_i,
  input  logic [dmr_cfg_pkg::NumGroups-1:0]    debug_rsp_i,
  input  recovery_pkg::rf_addr_t               gen_addr_i,
  input  logic                                 gen_done_i,
  output logic                                 clear_o,
  output logic                                 gen_enable_o,
  output logic [dmr_cfg_pkg::NumGroups-1:0]    core_rstn_o,
  output logic [dmr_cfg_pkg::NumGroups-1:0]    core_clk_en_o,
  output logic [dmr_cfg_pkg::NumGroups-1:0]    instr_lock_o,
  output logic [dmr_cfg_pkg::NumGroups-1:0]    debug_req_o,
  output logic [dmr_cfg_pkg::NumGroups-1:0]    recover_o,
  output logic                                 restore_we_o,
  output recovery_pkg::rf_addr_t               restore_addr_o,
  output logic                                 busy_o
);

  import dmr_cfg_pkg::*;
  import recovery_pkg::*;

  recovery_state_e      state_q;
  recovery_state_e      state_d;
  logic [NumGroups-1:0] lock_q;
  logic [NumGroups-1:0] lock_d;
  logic [NumGroups-1:0] recover_q;
  logic [NumGroups-1:0] recover_d;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = RESET;
        end
      end
      // single cycle reset pulse
      RESET: begin
        state_d = HALT_REQ;
      end
      HALT_REQ: begin
        state_d = HALT_WAIT;
      end
      // latency set by the debug module
      HALT_WAIT: begin
        if (debug_rsp_i[group_i]) begin
          state_d = RESTORE_RF;
        end
      end
      // generator paces the sweep
      RESTORE_RF: begin
        if (gen_done_i) begin
          state_d = RESUME;
        end
      end
      RESUME: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // lock and recover updates
  always_comb begin
    lock_d    = lock_q;
    recover_d = recover_q;
    case (state_q)
      // fetch locked from the cycle after reset
      RESET: begin
        lock_d[group_i] = 1'b1;
      end
      // recover up on entry to restore
      HALT_WAIT: begin
        if (debug_rsp_i[group_i]) begin
          recover_d[group_i] = 1'b1;
        end
      end
      // both low throughout resume
      RESTORE_RF: begin
        if (gen_done_i) begin
          lock_d[group_i]    = 1'b0;
          recover_d[group_i] = 1'b0;
        end
      end
      default: begin
        lock_d    = lock_q;
        recover_d = recover_q;
      end
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      lock_q    <= '0;
      recover_q <= '0;
    end else begin
      state_q   <= state_d;
      lock_q    <= lock_d;
      recover_q <= recover_d;
    end
  end

  // per pair pulses, only the faulty pair is touched
  always_comb begin
    core_rstn_o   = '1;
    core_clk_en_o = '1;
    debug_req_o   = '0;
    if (state_q == RESET) begin
      core_rstn_o[group_i]   = 1'b0;
      core_clk_en_o[group_i] = 1'b0;
    end
    if (state_q == HALT_REQ) begin
      debug_req_o[group_i] = 1'b1;
    end
  end

  assign instr_lock_o = lock_q;
  assign recover_o    = recover_q;

  // replay bus, one register per cycle
  assign gen_enable_o   = (state_q == RESTORE_RF);
  assign restore_we_o   = (state_q == RESTORE_RF);
  assign restore_addr_o = gen_addr_i;

  // releases the arbiter
  assign clear_o = (state_q == RESUME);
  assign busy_o  = (state_q != IDLE);

endmodule : dmr_recovery_ctrl

// ==== logic/dmr_recovery_top.sv ====
// replay bus is shared by all pairs and cannot stall; recover_o marks the target pair
`timescale 1ns/1ps

module dmr_recovery_top (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic [dmr_cfg_pkg::NumGroups-1:0]           rf_err_a_i,
  input  logic [dmr_cfg_pkg::NumGroups-1:0]           rf_err_b_i,
  input  logic [dmr_cfg_pkg::NumGroups-1:0]           core_err_main_i,
  input  logic [dmr_cfg_pkg::NumGroups-1:0]           core_err_data_i,
  input  logic [dmr_cfg_pkg::NumGroups-1:0]           core_we_i,
  input  recovery_pkg::rf_addr_t [dmr_cfg_pkg::NumGroups-1:0] core_waddr_i,
  input  recovery_pkg::rf_data_t [dmr_cfg_pkg::NumGroups-1:0] core_wdata_i,
  input  logic [dmr_cfg_pkg::NumGroups-1:0]           debug_rsp_i,
  output logic [dmr_cfg_pkg::NumGroups-1:0]           core_rstn_o,
  output logic [dmr_cfg_pkg::NumGroups-1:0]           core_clk_en_o,
  output logic [dmr_cfg_pkg::NumGroups-1:0]           instr_lock_o,
  output logic [dmr_cfg_pkg::NumGroups-1:0]           debug_req_o,
  output logic [dmr_cfg_pkg::NumGroups-1:0]           recover_o,
  output logic                                        restore_we_o,
  output recovery_pkg::rf_addr_t                      restore_addr_o,
  output recovery_pkg::rf_data_t                      restore_data_o,
  output logic                                        busy_o
);

  import dmr_cfg_pkg::*;
  import recovery_pkg::*;

  logic                 start;
  logic                 clear;
  group_idx_t           group;
  logic [NumGroups-1:0] err_flags;
  logic                 gen_enable;
  rf_addr_t             gen_addr;
  logic                 gen_done;

  // picks the pair to recover
  dmr_error_arbiter u_arbiter (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .rf_err_a_i      ( rf_err_a_i      ),
    .rf_err_b_i      ( rf_err_b_i      ),
    .core_err_main_i ( core_err_main_i ),
    .core_err_data_i ( core_err_data_i ),
    .clear_i         ( clear           ),
    .start_o         ( start           ),
    .group_o         ( group           ),
    .error_o         ( err_flags       )
  );

  // replay address sweep
  rf_addr_gen u_addr_gen (
    .clk_i    ( clk_i      ),
    .rst_ni   ( rst_ni     ),
    .enable_i ( gen_enable ),
    .addr_o   ( gen_addr   ),
    .done_o   ( gen_done   )
  );

  // shadow copy, read by generator address of the faulty pair
  recovery_regfile u_rrf (
    .clk_i      ( clk_i          ),
    .rst_ni     ( rst_ni         ),
    .error_i    ( err_flags      ),
    .recover_i  ( recover_o      ),
    .wr_en_i    ( core_we_i      ),
    .wr_addr_i  ( core_waddr_i   ),
    .wr_data_i  ( core_wdata_i   ),
    .rd_group_i ( group          ),
    .rd_addr_i  ( gen_addr       ),
    .rd_data_o  ( restore_data_o )
  );

  // routine sequencing
  dmr_recovery_ctrl u_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .start_i        ( start          ),
    .group_i        ( group          ),
    .debug_rsp_i    ( debug_rsp_i    ),
    .gen_addr_i     ( gen_addr       ),
    .gen_done_i     ( gen_done       ),
    .clear_o        ( clear          ),
    .gen_enable_o   ( gen_enable     ),
    .core_rstn_o    ( core_rstn_o    ),
    .core_clk_en_o  ( core_clk_en_o  ),
    .instr_lock_o   ( instr_lock_o   ),
    .debug_req_o    ( debug_req_o    ),
    .recover_o      ( recover_o      ),
    .restore_we_o   ( restore_we_o   ),
    .restore_addr_o ( restore_addr_o ),
    .busy_o         ( busy_o         )
  );

endmodule : dmr_recovery_top

// ==== verification/tb_dmr_recovery.sv ====
// written for four pairs of 32 registers; checks are immediate asserts, so build with --assert
`timescale 1ns/1ps

module tb_dmr_recovery;

  import dmr_cfg_pkg::*;
  import recovery_pkg::*;

  // cycles any single wait may take before giving up
  localparam int WaitLimit = 8;

  logic                           clk_i = 1'b0;
  logic                           rst_ni;
  logic     [NumGroups-1:0]       rf_err_a;
  logic     [NumGroups-1:0]       rf_err_b;
  logic     [NumGroups-1:0]       core_err_main;
  logic     [NumGroups-1:0]       core_err_data;
  logic     [NumGroups-1:0]       core_we;
  rf_addr_t [NumGroups-1:0]       core_waddr;
  rf_data_t [NumGroups-1:0]       core_wdata;
  logic     [NumGroups-1:0]       debug_rsp;
  logic     [NumGroups-1:0]       core_rstn;
  logic     [NumGroups-1:0]       core_clk_en;
  logic     [NumGroups-1:0]       instr_lock;
  logic     [NumGroups-1:0]       debug_req;
  logic     [NumGroups-1:0]       recover;
  logic                           restore_we;
  rf_addr_t                       restore_addr;
  rf_data_t                       restore_data;
  logic                           busy;

  // reference copy of the trusted register files
  rf_data_t shadow [NumGroups][NumRegs];
  integer   seed;
  int       errors;
  int       timeouts;

  dmr_recovery_top dut0 (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .rf_err_a_i      ( rf_err_a      ),
    .rf_err_b_i      ( rf_err_b      ),
    .core_err_main_i ( core_err_main ),
    .core_err_data_i ( core_err_data ),
    .core_we_i       ( core_we       ),
    .core_waddr_i    ( core_waddr    ),
    .core_wdata_i    ( core_wdata    ),
    .debug_rsp_i     ( debug_rsp     ),
    .core_rstn_o     ( core_rstn     ),
    .core_clk_en_o   ( core_clk_en   ),
    .instr_lock_o    ( instr_lock    ),
    .debug_req_o     ( debug_req     ),
    .recover_o       ( recover       ),
    .restore_we_o    ( restore_we    ),
    .restore_addr_o  ( restore_addr  ),
    .restore_data_o  ( restore_data  ),
    .busy_o          ( busy          )
  );

  always #5 clk_i = ~clk_i;

  task automatic report_mismatch(input string msg);
    errors++;
    $display("Fail at time %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string msg);
    timeouts++;
    $display("Timeout at time %0t: %s", $time, msg);
  endtask

  // random core writes and the given errors for one cycle up to the next negedge
  task automatic drive_cycle(input logic [NumGroups-1:0] err_pairs,
                             input logic [NumGroups-1:0] rec_mask);
    int g;
    int src;
    rf_err_a      = '0;
    rf_err_b      = '0;
    core_err_main = '0;
    core_err_data = '0;
    for (g = 0; g < NumGroups; g++) begin
      core_we[g]    = ($random(seed) & 1) != 0;
      core_waddr[g] = rf_addr_t'($random(seed));
      core_wdata[g] = rf_data_t'($random(seed));
      // any of the four checkers may flag the pair
      if (err_pairs[g]) begin
        // a flagged pair always offers a write that must be dropped
        core_we[g] = 1'b1;
        src = $random(seed) & 3;
        case (src)
          0: rf_err_a[g] = 1'b1;
          1: rf_err_b[g] = 1'b1;
          2: core_err_main[g] = 1'b1;
          default: core_err_data[g] = 1'b1;
        endcase
      end
      // flagged or replayed pair keeps its old word
      if (core_we[g] && !err_pairs[g] && !rec_mask[g]) begin
        shadow[g][core_waddr[g]] = core_wdata[g];
      end
    end
    @(negedge clk_i);
  endtask

  // no routine running
  task automatic check_quiet(input string where);
    assert (core_rstn == '1 && core_clk_en == '1) else report_mismatch($sformatf(
      "%s: reset %b clock enable %b, expected all high", where, core_rstn, core_clk_en));
    assert (instr_lock == '0 && recover == '0) else report_mismatch($sformatf(
      "%s: lock %b recover %b, expected all low", where, instr_lock, recover));
    assert (debug_req == '0 && !restore_we && !busy) else report_mismatch($sformatf(
      "%s: debug req %b strobe %b busy %b, expected low", where, debug_req, restore_we, busy));
  endtask

  // halt wait with fetch locked on the faulty pair only
  task automatic check_halt_wait(input logic [NumGroups-1:0] mask);
    assert (debug_req == '0 && core_rstn == '1 && instr_lock == mask) else report_mismatch(
      $sformatf("halt wait: debug req %b reset %b lock %b", debug_req, core_rstn, instr_lock));
    assert (recover == '0 && !restore_we && busy) else report_mismatch($sformatf(
      "halt wait: recover %b strobe %b busy %b before response", recover, restore_we, busy));
  endtask

  // one full routine from an error on err_pairs that must recover pair exp_g
  task automatic run_recovery(input logic [NumGroups-1:0] err_pairs, input int exp_g,
                              input bit late_err);
    logic [NumGroups-1:0] mask;
    int                   delay;
    int                   waited;
    int                   i;
    mask       = '0;
    mask[exp_g] = 1'b1;
    delay      = 1 + ($random(seed) & 15);
    // fill the files with trusted writes first
    for (i = 0; i < 6; i++) begin
      check_quiet("before error");
      drive_cycle('0, '0);
    end
    drive_cycle(err_pairs, '0);
    // routine starts one edge after the index latches
    check_quiet("start cycle");
    drive_cycle('0, '0);
    assert (core_rstn == ~mask && core_clk_en == ~mask) else report_mismatch($sformatf(
      "reset step: reset %b clock enable %b on pair %0d", core_rstn, core_clk_en, exp_g));
    assert (instr_lock == '0 && debug_req == '0 && busy) else report_mismatch($sformatf(
      "reset step: lock %b debug req %b busy %b", instr_lock, debug_req, busy));
    drive_cycle('0, '0);
    assert (debug_req == mask && instr_lock == mask) else report_mismatch($sformatf(
      "halt request: debug req %b lock %b on pair %0d", debug_req, instr_lock, exp_g));
    assert (core_rstn == '1 && core_clk_en == '1 && busy) else report_mismatch($sformatf(
      "halt request: reset %b clock enable %b busy %b", core_rstn, core_clk_en, busy));
    drive_cycle('0, '0);
    // other pairs answer at random while the response is held back
    for (i = 0; i < delay; i++) begin
      check_halt_wait(mask);
      debug_rsp = NumGroups'($random(seed)) & ~mask;
      if (late_err && i == 0) begin
        // must not restart or retarget the routine
        drive_cycle(~mask, '0);
      end else begin
        drive_cycle('0, '0);
      end
    end
    check_halt_wait(mask);
    debug_rsp = mask;
    drive_cycle('0, '0);
    waited = 0;
    while (!restore_we && waited < WaitLimit) begin
      drive_cycle('0, '0);
      waited++;
    end
    if (!restore_we) begin
      report_timeout("replay strobe never rose after the halt response");
      return;
    end
    assert (waited == 0) else report_mismatch($sformatf(
      "replay started %0d cycles late", waited));
    debug_rsp = '0;
    // all registers in order while writes to this pair are dropped
    for (i = 0; i < NumRegs; i++) begin
      assert (restore_we && restore_addr == rf_addr_t'(i)) else report_mismatch($sformatf(
        "replay step %0d: strobe %b addr %0d", i, restore_we, restore_addr));
      assert (restore_data == shadow[exp_g][i]) else report_mismatch($sformatf(
        "replay data at register %0d is %h, expected %h", i, restore_data,
        shadow[exp_g][i]));
      assert (recover == mask && instr_lock == mask && busy) else report_mismatch($sformatf(
        "replay step %0d: recover %b lock %b busy %b", i, recover, instr_lock, busy));
      drive_cycle('0, mask);
    end
    // resume step
    assert (!restore_we && instr_lock == '0 && recover == '0 && busy) else report_mismatch(
      $sformatf("resume: strobe %b lock %b recover %b busy %b", restore_we, instr_lock,
      recover, busy));
    drive_cycle('0, '0);
    waited = 0;
    while (busy && waited < WaitLimit) begin
      drive_cycle('0, '0);
      waited++;
    end
    if (busy) begin
      report_timeout("busy did not fall after the resume step");
      return;
    end
    // no second routine from a late error
    for (i = 0; i < 4; i++) begin
      check_quiet("after routine");
      drive_cycle('0, '0);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  initial begin
    int g;
    int r;
    int n;
    seed          = 86;
    errors        = 0;
    timeouts      = 0;
    rst_ni        = 1'b0;
    rf_err_a      = '0;
    rf_err_b      = '0;
    core_err_main = '0;
    core_err_data = '0;
    core_we       = '0;
    core_waddr    = '0;
    core_wdata    = '0;
    debug_rsp     = '0;
    for (g = 0; g < NumGroups; g++) begin
      for (r = 0; r < NumRegs; r++) begin
        shadow[g][r] = '0;
      end
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // idle writes never disturb the outputs
    for (n = 0; n < 20; n++) begin
      check_quiet("idle");
      drive_cycle('0, '0);
    end
    run_recovery(4'b0010, 1, 1'b0);
    // several pairs at once where the highest one wins
    if (timeouts == 0) run_recovery(4'b0111, 2, 1'b0);
    if (timeouts == 0) run_recovery(4'b0001, 0, 1'b1);
    // fresh error once busy is low
    if (timeouts == 0) run_recovery(4'b1000, 3, 1'b0);
    if (timeouts == 0) run_recovery(4'b0100, 2, 1'b1);
    finish_run();
  end

endmodule : tb_dmr_recovery

// ==== files.f ====
logic/dmr_cfg_pkg.sv
logic/recovery_pkg.sv
logic/dmr_error_arbiter.sv
logic/rf_addr_gen.sv
logic/recovery_regfile.sv
logic/dmr_recovery_ctrl.sv
logic/dmr_recovery_top.sv
verification/tb_dmr_recovery.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
  --top-module tb_dmr_recovery -f files.f \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_dmr_recovery | tee /dev/stderr | grep -qx "RESULT: PASS" \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
